// File: tiled_ram_top.f
+incdir+include
source/tiled_ram_cfg_pkg.sv
source/tiled_ram_req_pkg.sv
source/ram_port_arbiter.sv
source/ram_addr_rd_pipe.sv
source/ram_tile.sv
source/ram_data_rd_pipe.sv
source/tiled_ram_top.sv
bench/tiled_ram_tb.sv

// File: Bender.yml
package:
  name: tiled_ram

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/tiled_ram_cfg_pkg.sv
      - source/tiled_ram_req_pkg.sv
      - source/ram_port_arbiter.sv
      - source/ram_addr_rd_pipe.sv
      - source/ram_tile.sv
      - source/ram_data_rd_pipe.sv
      - source/tiled_ram_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tiled_ram_tb.sv

// File: bench/tiled_ram_tb.sv
// Tiled RAM testbench with a reference memory model, round-robin model and response checks
`timescale 1ns/100ps
`include "tiled_ram_defines.svh"

module tiled_ram_tb;

  localparam int DEPTH  = `TILED_RAM_DEPTH;
  localparam int LAT    = `TILED_RAM_ADDR_STAGES + 1 + `TILED_RAM_DATA_STAGES;
  localparam int B2B_N  = 16;
  localparam int FAIR_N = 8;
  localparam int RAW_N  = 4;
  localparam int RAND_N = 300;
  // Cycles of all six tests, then latency slack per test and a margin
  localparam int TEST_CYCLES = 5 + 2 * DEPTH + B2B_N + 3 * FAIR_N + 2 * RAW_N + RAND_N;
  localparam int TIMEOUT     = TEST_CYCLES + 6 * 2 * LAT + 100;

  logic                     clk;
  logic                     rst_n;
  logic                     wr_req;
  tiled_ram_cfg_pkg::addr_t wr_addr;
  tiled_ram_cfg_pkg::data_t wr_data;
  logic                     wr_gnt;
  logic                     rd_req_0;
  tiled_ram_cfg_pkg::addr_t rd_addr_0;
  logic                     rd_gnt_0;
  logic                     rd_req_1;
  tiled_ram_cfg_pkg::addr_t rd_addr_1;
  logic                     rd_gnt_1;
  logic                     rd_valid_0;
  tiled_ram_cfg_pkg::data_t rd_data_0;
  logic                     rd_valid_1;
  tiled_ram_cfg_pkg::data_t rd_data_1;

  // Memory model, updated at each granted write
  tiled_ram_cfg_pkg::data_t   model [DEPTH];
  // Expected responses, ordered by due cycle
  tiled_ram_cfg_pkg::data_t   exp_data [$];
  int                         exp_due [$];
  int                         exp_reader [$];
  tiled_ram_req_pkg::client_t rr_last;
  // Grant cycle per client, indexed by client value
  int                         granted_at [3];
  int                         cyc;
  int                         errors;
  int                         test_errors;
  int                         pass_count;
  int                         fail_count;
  string                      test_name;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Posedge count, read only at falling edges
  always @(posedge clk) cyc <= cyc + 1;

  tiled_ram_top i_tiled_ram_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_gnt     (wr_gnt),
    .rd_req_0   (rd_req_0),
    .rd_addr_0  (rd_addr_0),
    .rd_gnt_0   (rd_gnt_0),
    .rd_req_1   (rd_req_1),
    .rd_addr_1  (rd_addr_1),
    .rd_gnt_1   (rd_gnt_1),
    .rd_valid_0 (rd_valid_0),
    .rd_data_0  (rd_data_0),
    .rd_valid_1 (rd_valid_1),
    .rd_data_1  (rd_data_1)
  );

  // --------------------
  // Reference and compare
  // --------------------

  // Last word granted to this address
  function automatic tiled_ram_cfg_pkg::data_t expected_word(tiled_ram_cfg_pkg::addr_t a);
    return model[a];
  endfunction

  // Priority list rotates so the client after the last winner comes first
  function automatic tiled_ram_req_pkg::client_t next_winner(
    tiled_ram_req_pkg::client_t last, logic [2:0] req);
    tiled_ram_req_pkg::client_t order [3];
    case (last)
      tiled_ram_req_pkg::WRITER: begin
        order = '{tiled_ram_req_pkg::READER_0, tiled_ram_req_pkg::READER_1,
                  tiled_ram_req_pkg::WRITER};
      end
      tiled_ram_req_pkg::READER_0: begin
        order = '{tiled_ram_req_pkg::READER_1, tiled_ram_req_pkg::WRITER,
                  tiled_ram_req_pkg::READER_0};
      end
      default: begin
        order = '{tiled_ram_req_pkg::WRITER, tiled_ram_req_pkg::READER_0,
                  tiled_ram_req_pkg::READER_1};
      end
    endcase
    for (int i = 2; i >= 0; i--) begin
      if (req[order[i]]) last = order[i];
    end
    return last;
  endfunction

  task automatic check_data(tiled_ram_cfg_pkg::data_t exp, tiled_ram_cfg_pkg::data_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected %h, actual %h", test_name, exp, act);
      errors++;
    end
  endtask

  task automatic check_client(tiled_ram_req_pkg::client_t exp, tiled_ram_req_pkg::client_t act);
    if (act !== exp) begin
      $display("Mismatch in %s (grant winner): expected %0d, actual %0d", test_name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) begin
      $display("Mismatch in %s (%s): expected %b, actual %b", test_name, what, exp, act);
      errors++;
    end
  endtask

  // --------------------
  // Monitors
  // --------------------

  // Grants settle 1 ns after the falling edge drive
  always begin : grant_monitor
    logic [2:0]                 req;
    logic [2:0]                 gnt;
    tiled_ram_req_pkg::client_t exp;
    @(negedge clk);
    #1;
    req = {rd_req_1, rd_req_0, wr_req};
    gnt = {rd_gnt_1, rd_gnt_0, wr_gnt};
    if (!rst_n) begin
      rr_last = tiled_ram_req_pkg::READER_1;
    end else if (req == 3'b000) begin
      check_flag("grant without request", 1'b0, |gnt);
    end else begin
      exp = next_winner(rr_last, req);
      rr_last = exp;
      case (gnt)
        3'b001: check_client(exp, tiled_ram_req_pkg::WRITER);
        3'b010: check_client(exp, tiled_ram_req_pkg::READER_0);
        3'b100: check_client(exp, tiled_ram_req_pkg::READER_1);
        default: begin
          $display("Error in %s: grants %b are not a single winner", test_name, gnt);
          errors++;
        end
      endcase
      // Model follows what the DUT actually granted
      if (gnt[0]) model[wr_addr] = wr_data;
      for (int r = 0; r < 2; r++) begin
        if (gnt[r+1]) begin
          exp_data.push_back(expected_word(r == 0 ? rd_addr_0 : rd_addr_1));
          exp_due.push_back(cyc + LAT);
          exp_reader.push_back(r);
        end
      end
    end
  end

  // Read responses are registered, stable at the falling edge
  always begin : response_monitor
    logic [1:0] v;
    int         r;
    @(negedge clk);
    v = {rd_valid_1, rd_valid_0};
    while (exp_due.size() != 0 && exp_due[0] < cyc) begin
      $display("Error in %s: reader %0d response missing at its due cycle %0d",
               test_name, exp_reader[0], exp_due[0]);
      errors++;
      void'(exp_data.pop_front());
      void'(exp_due.pop_front());
      void'(exp_reader.pop_front());
    end
    if (exp_due.size() != 0 && exp_due[0] == cyc) begin
      r = exp_reader[0];
      if (!v[r]) begin
        $display("Error in %s: reader %0d response missing at its due cycle %0d",
                 test_name, r, cyc);
        errors++;
      end else begin
        check_data(exp_data[0], r == 0 ? rd_data_0 : rd_data_1);
      end
      // Only the issuing reader sees the word
      check_flag("other reader valid", 1'b0, v[1-r]);
      void'(exp_data.pop_front());
      void'(exp_due.pop_front());
      void'(exp_reader.pop_front());
    end else if (v != 2'b00) begin
      $display("Error in %s: response at cycle %0d with none expected", test_name, cyc);
      errors++;
    end
  end

  // --------------------
  // Client drivers
  // --------------------

  // Called at a falling edge, returns at a later falling edge with the request dropped
  task automatic write_word(tiled_ram_cfg_pkg::addr_t a, tiled_ram_cfg_pkg::data_t d);
    int start;
    start   = cyc;
    wr_req  = 1'b1;
    wr_addr = a;
    wr_data = d;
    #1;
    while (!wr_gnt) begin
      @(negedge clk);
      #1;
    end
    granted_at[0] = cyc;
    check_flag("writer granted within three cycles", 1'b1, cyc - start < 3);
    @(negedge clk);
    wr_req = 1'b0;
  endtask

  task automatic read_word(int r, tiled_ram_cfg_pkg::addr_t a);
    int start;
    start = cyc;
    if (r == 0) begin
      rd_req_0  = 1'b1;
      rd_addr_0 = a;
    end else begin
      rd_req_1  = 1'b1;
      rd_addr_1 = a;
    end
    #1;
    while (!(r == 0 ? rd_gnt_0 : rd_gnt_1)) begin
      @(negedge clk);
      #1;
    end
    granted_at[r+1] = cyc;
    check_flag("reader granted within three cycles", 1'b1, cyc - start < 3);
    @(negedge clk);
    if (r == 0) rd_req_0 = 1'b0;
    else        rd_req_1 = 1'b0;
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_errors = errors;
  endtask

  // Drain in-flight reads, then report the test
  task automatic end_test();
    while (exp_due.size() != 0) @(negedge clk);
    @(negedge clk);
    if (errors == test_errors) begin
      pass_count++;
      $display("%s: passed", test_name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", test_name, errors - test_errors);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  initial begin : watchdog
    while (cyc < TIMEOUT) @(negedge clk);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    int                       prev;
    int                       stop;
    tiled_ram_cfg_pkg::addr_t a;
    void'($urandom(68));
    rst_n     = 1'b0;
    wr_req    = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    rd_req_0  = 1'b0;
    rd_addr_0 = '0;
    rd_req_1  = 1'b0;
    rd_addr_1 = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Idle outputs after reset
    begin_test("reset_idle");
    repeat (5) begin
      #1;
      check_flag("wr_gnt idle", 1'b0, wr_gnt);
      check_flag("rd_gnt_0 idle", 1'b0, rd_gnt_0);
      check_flag("rd_gnt_1 idle", 1'b0, rd_gnt_1);
      check_flag("rd_valid_0 idle", 1'b0, rd_valid_0);
      check_flag("rd_valid_1 idle", 1'b0, rd_valid_1);
      @(negedge clk);
    end
    end_test();

    // Every address crosses all depth tiles
    begin_test("fill_readback");
    for (int i = 0; i < DEPTH; i++) write_word(tiled_ram_cfg_pkg::addr_t'(i), $urandom);
    for (int i = 0; i < DEPTH; i++) read_word(0, tiled_ram_cfg_pkg::addr_t'(i));
    end_test();

    begin_test("back_to_back_reads");
    prev = 0;
    for (int i = 0; i < B2B_N; i++) begin
      read_word(1, tiled_ram_cfg_pkg::addr_t'($urandom));
      if (i > 0) check_flag("consecutive grant", 1'b1, granted_at[2] == prev + 1);
      prev = granted_at[2];
    end
    end_test();

    // Grant order itself is checked by the grant monitor
    begin_test("round_robin");
    fork
      for (int i = 0; i < FAIR_N; i++) write_word(tiled_ram_cfg_pkg::addr_t'($urandom), $urandom);
      for (int i = 0; i < FAIR_N; i++) read_word(0, tiled_ram_cfg_pkg::addr_t'($urandom));
      for (int i = 0; i < FAIR_N; i++) read_word(1, tiled_ram_cfg_pkg::addr_t'($urandom));
    join
    end_test();

    begin_test("read_after_write");
    for (int i = 0; i < RAW_N; i++) begin
      a = tiled_ram_cfg_pkg::addr_t'($urandom);
      write_word(a, $urandom);
      read_word(0, a);
      check_flag("read grant follows write", 1'b1, granted_at[1] == granted_at[0] + 1);
    end
    end_test();

    begin_test("random_traffic");
    stop = cyc + RAND_N;
    fork
      while (cyc < stop) begin
        if ($urandom_range(1, 0) == 1) write_word(tiled_ram_cfg_pkg::addr_t'($urandom), $urandom);
        else @(negedge clk);
      end
      while (cyc < stop) begin
        if ($urandom_range(1, 0) == 1) read_word(0, tiled_ram_cfg_pkg::addr_t'($urandom));
        else @(negedge clk);
      end
      while (cyc < stop) begin
        if ($urandom_range(1, 0) == 1) read_word(1, tiled_ram_cfg_pkg::addr_t'($urandom));
        else @(negedge clk);
      end
    join
    end_test();

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tiled_ram_tb

// File: source/tiled_ram_top.sv
// Tiled RAM top level shared by one writer and two readers
`timescale 1ns/100ps
`include "tiled_ram_defines.svh"

module tiled_ram_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wr_req,
  input  tiled_ram_cfg_pkg::addr_t wr_addr,
  input  tiled_ram_cfg_pkg::data_t wr_data,
  output logic                     wr_gnt,
  input  logic                     rd_req_0,
  input  tiled_ram_cfg_pkg::addr_t rd_addr_0,
  output logic                     rd_gnt_0,
  input  logic                     rd_req_1,
  input  tiled_ram_cfg_pkg::addr_t rd_addr_1,
  output logic                     rd_gnt_1,
  output logic                     rd_valid_0,
  output tiled_ram_cfg_pkg::data_t rd_data_0,
  output logic                     rd_valid_1,
  output tiled_ram_cfg_pkg::data_t rd_data_1
);

  localparam int DT = `TILED_RAM_DEPTH_TILES;
  localparam int WT = `TILED_RAM_WIDTH_TILES;
  localparam int TW = $bits(tiled_ram_cfg_pkg::tile_word_t);

  // Arbiter to address pipe
  logic                          cmd_valid;
  tiled_ram_req_pkg::cmd_t       cmd_kind;
  tiled_ram_cfg_pkg::addr_t      cmd_addr;
  tiled_ram_cfg_pkg::data_t      cmd_wdata;

  // Address pipe to tiles
  logic [DT-1:0]                 tile_en;
  logic                          tile_we;
  tiled_ram_cfg_pkg::tile_addr_t tile_row;
  tiled_ram_cfg_pkg::data_t      tile_wdata;

  // Tiles to data pipe
  logic [DT-1:0][WT-1:0]                          tile_valid;
  tiled_ram_cfg_pkg::tile_word_t [DT-1:0][WT-1:0] tile_data;

  // Data pipe back to arbiter
  logic                          rsp_valid;
  tiled_ram_cfg_pkg::data_t      rsp_data;

  // --------------------
  // Front end
  // --------------------
  ram_port_arbiter i_arbiter (
    .clk, .rst_n,
    .wr_req, .wr_addr, .wr_data,
    .rd_req_0, .rd_addr_0, .rd_req_1, .rd_addr_1,
    .rsp_valid, .rsp_data,
    .wr_gnt, .rd_gnt_0, .rd_gnt_1,
    .cmd_valid, .cmd_kind, .cmd_addr, .cmd_wdata,
    .rd_valid_0, .rd_data_0, .rd_valid_1, .rd_data_1
  );

  ram_addr_rd_pipe i_addr_pipe (
    .clk, .rst_n,
    .cmd_valid, .cmd_kind, .cmd_addr, .cmd_wdata,
    .tile_en, .tile_we, .tile_row, .tile_wdata
  );

  // --------------------
  // Tile array
  // --------------------

  // Each width tile stores its own slice of the word
  for (genvar d = 0; d < DT; d++) begin : gen_depth
    for (genvar w = 0; w < WT; w++) begin : gen_width
      ram_tile i_tile (
        .clk, .rst_n,
        .en         (tile_en[d]),
        .we         (tile_we),
        .row        (tile_row),
        .wdata      (tile_wdata[w*TW +: TW]),
        .read_valid (tile_valid[d][w]),
        .read_data  (tile_data[d][w])
      );
    end
  end

  ram_data_rd_pipe i_data_pipe (
    .clk, .rst_n,
    .tile_valid, .tile_data,
    .valid (rsp_valid),
    .data  (rsp_data)
  );

endmodule : tiled_ram_top

// File: source/ram_data_rd_pipe.sv
// Read data pipeline that merges tile outputs into one valid word
`timescale 1ns/100ps
`include "tiled_ram_defines.svh"

module ram_data_rd_pipe (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [`TILED_RAM_DEPTH_TILES-1:0][`TILED_RAM_WIDTH_TILES-1:0] tile_valid,
  input  tiled_ram_cfg_pkg::tile_word_t [`TILED_RAM_DEPTH_TILES-1:0][`TILED_RAM_WIDTH_TILES-1:0]
                                              tile_data,
  output logic                                valid,
  output tiled_ram_cfg_pkg::data_t            data
);

  localparam int DT     = `TILED_RAM_DEPTH_TILES;
  localparam int STAGES = `TILED_RAM_DATA_STAGES;
  // Levels in the depth reduction tree
  localparam int LEVELS = $clog2(DT);

  // Per depth tile valid after the width-wise reduction
  logic [DT-1:0] depth_valid;

  // --------------------
  // Reduction tree
  // --------------------

  // Level 0 is the leaves and each level halves the candidates
  // Levels 1 to STAGES end in a register
  for (genvar l = 0; l <= LEVELS; l++) begin : gen_lvl
    localparam int N = DT >> l;
    logic [N-1:0]                      v;
    tiled_ram_cfg_pkg::data_t [N-1:0]  w;

    if (l == 0) begin : gen_leaf
      for (genvar d = 0; d < DT; d++) begin : gen_d
        assign depth_valid[d] = |tile_valid[d];
        // Width slices join with slice 0 in the LSBs
        assign w[d] = tile_data[d];
      end
      assign v = depth_valid;
    end else begin : gen_node
      logic [N-1:0]                     vn;
      tiled_ram_cfg_pkg::data_t [N-1:0] wn;

      // Pairwise merge, the valid side wins
      for (genvar n = 0; n < N; n++) begin : gen_n
        assign vn[n] = gen_lvl[l-1].v[2*n] | gen_lvl[l-1].v[2*n+1];
        assign wn[n] = gen_lvl[l-1].v[2*n] ? gen_lvl[l-1].w[2*n] : gen_lvl[l-1].w[2*n+1];
      end

      if (l <= STAGES) begin : gen_reg
        always_ff @(posedge clk or negedge rst_n) begin
          if (!rst_n) begin
            v <= '0;
          end else begin
            v <= vn;
          end
        end
        always_ff @(posedge clk) begin
          w <= wn;
        end
      end else begin : gen_wire
        assign v = vn;
        assign w = wn;
      end
    end
  end

  // Root of the tree
  assign valid = gen_lvl[LEVELS].v[0];
  assign data  = gen_lvl[LEVELS].w[0];

  // --------------------
  // Checks
  // --------------------

  // Width tiles of one depth tile are read together
  for (genvar d = 0; d < DT; d++) begin : gen_lockstep
    width_lockstep_a: assert property (@(posedge clk) disable iff (!rst_n)
      (tile_valid[d] == '0) || (tile_valid[d] == '1));
  end

  // Only one depth tile answers per cycle
  depth_onehot0_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(depth_valid));

  // Every tile read reaches the output after the pipeline delay
  valid_propagation_a: assert property (@(posedge clk) disable iff (!rst_n)
    |tile_valid |-> ##STAGES valid);

endmodule : ram_data_rd_pipe

// File: source/ram_tile.sv
// Single RAM tile with synchronous write and one-cycle registered read
`timescale 1ns/100ps
`include "tiled_ram_defines.svh"

module ram_tile (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  logic                          we,
  input  tiled_ram_cfg_pkg::tile_addr_t row,
  input  tiled_ram_cfg_pkg::tile_word_t wdata,
  output logic                          read_valid,
  output tiled_ram_cfg_pkg::tile_word_t read_data
);

  // Rows held by one depth tile
  localparam int TILE_DEPTH = `TILED_RAM_DEPTH / `TILED_RAM_DEPTH_TILES;

  // Storage array
  tiled_ram_cfg_pkg::tile_word_t mem [TILE_DEPTH];

  // --------------------
  // Write port
  // --------------------
  always_ff @(posedge clk) begin
    if (en && we) begin
      mem[row] <= wdata;
    end
  end

  // --------------------
  // Read port
  // --------------------

  // Data register holds its value between reads
  always_ff @(posedge clk) begin
    if (en && !we) begin
      read_data <= mem[row];
    end
  end

  // Valid follows a read enable by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_valid <= 1'b0;
    end else begin
      read_valid <= en && !we;
    end
  end

endmodule : ram_tile

// File: source/ram_addr_rd_pipe.sv
// Address pipeline that decodes the depth tile and carries commands to the tiles
`timescale 1ns/100ps
`include "tiled_ram_defines.svh"

module ram_addr_rd_pipe (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    cmd_valid,
  input  tiled_ram_req_pkg::cmd_t                 cmd_kind,
  input  tiled_ram_cfg_pkg::addr_t                cmd_addr,
  input  tiled_ram_cfg_pkg::data_t                cmd_wdata,
  output logic [`TILED_RAM_DEPTH_TILES-1:0]       tile_en,
  output logic                                    tile_we,
  output tiled_ram_cfg_pkg::tile_addr_t           tile_row,
  output tiled_ram_cfg_pkg::data_t                tile_wdata
);

  localparam int STAGES   = `TILED_RAM_ADDR_STAGES;
  localparam int DT       = `TILED_RAM_DEPTH_TILES;
  localparam int ADDR_W   = $bits(tiled_ram_cfg_pkg::addr_t);
  localparam int IDX_W    = $bits(tiled_ram_cfg_pkg::tile_idx_t);

  tiled_ram_cfg_pkg::tile_idx_t  tile_idx;
  logic [DT-1:0]                 en_d;
  logic                          we_d;
  tiled_ram_cfg_pkg::tile_addr_t row_d;

  // --------------------
  // Decode
  // --------------------

  // Upper address bits pick the tile, lower bits the row
  assign tile_idx = cmd_addr[ADDR_W-1 -: IDX_W];
  assign row_d    = cmd_addr[$bits(tiled_ram_cfg_pkg::tile_addr_t)-1:0];

  // One-hot enable, all zero when idle
  assign en_d = cmd_valid ? (DT'(1) << tile_idx) : '0;
  assign we_d = cmd_valid && (cmd_kind == tiled_ram_req_pkg::CMD_WRITE);

  // --------------------
  // Stage registers
  // --------------------
  if (STAGES == 0) begin : gen_comb
    assign tile_en    = en_d;
    assign tile_we    = we_d;
    assign tile_row   = row_d;
    assign tile_wdata = cmd_wdata;
  end else begin : gen_regs
    logic [DT-1:0]                 en_q    [STAGES];
    logic                          we_q    [STAGES];
    tiled_ram_cfg_pkg::tile_addr_t row_q   [STAGES];
    tiled_ram_cfg_pkg::data_t      wdata_q [STAGES];

    // Enables and write strobe are control
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int s = 0; s < STAGES; s++) begin
          en_q[s] <= '0;
          we_q[s] <= 1'b0;
        end
      end else begin
        en_q[0] <= en_d;
        we_q[0] <= we_d;
        for (int s = 1; s < STAGES; s++) begin
          en_q[s] <= en_q[s-1];
          we_q[s] <= we_q[s-1];
        end
      end
    end

    // Row and write data ride along
    always_ff @(posedge clk) begin
      row_q[0]   <= row_d;
      wdata_q[0] <= cmd_wdata;
      for (int s = 1; s < STAGES; s++) begin
        row_q[s]   <= row_q[s-1];
        wdata_q[s] <= wdata_q[s-1];
      end
    end

    assign tile_en    = en_q[STAGES-1];
    assign tile_we    = we_q[STAGES-1];
    assign tile_row   = row_q[STAGES-1];
    assign tile_wdata = wdata_q[STAGES-1];
  end

  // At most one depth tile sees the command
  tile_en_onehot0_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(tile_en));

endmodule : ram_addr_rd_pipe

// File: source/ram_port_arbiter.sv
// Round-robin arbiter for one writer and two readers with read-response steering
`timescale 1ns/100ps
`include "tiled_ram_defines.svh"

module ram_port_arbiter (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wr_req,
  input  tiled_ram_cfg_pkg::addr_t    wr_addr,
  input  tiled_ram_cfg_pkg::data_t    wr_data,
  input  logic                        rd_req_0,
  input  tiled_ram_cfg_pkg::addr_t    rd_addr_0,
  input  logic                        rd_req_1,
  input  tiled_ram_cfg_pkg::addr_t    rd_addr_1,
  input  logic                        rsp_valid,
  input  tiled_ram_cfg_pkg::data_t    rsp_data,
  output logic                        wr_gnt,
  output logic                        rd_gnt_0,
  output logic                        rd_gnt_1,
  output logic                        cmd_valid,
  output tiled_ram_req_pkg::cmd_t     cmd_kind,
  output tiled_ram_cfg_pkg::addr_t    cmd_addr,
  output tiled_ram_cfg_pkg::data_t    cmd_wdata,
  output logic                        rd_valid_0,
  output tiled_ram_cfg_pkg::data_t    rd_data_0,
  output logic                        rd_valid_1,
  output tiled_ram_cfg_pkg::data_t    rd_data_1
);

  // Fixed grant-to-response latency of a read
  localparam int RD_LATENCY = `TILED_RAM_ADDR_STAGES + 1 + `TILED_RAM_DATA_STAGES;

  logic [tiled_ram_req_pkg::NUM_CLIENTS-1:0] req;
  logic                                      any_req;
  tiled_ram_req_pkg::client_t                winner;
  tiled_ram_req_pkg::client_t                last_q;
  // Reader ownership per in-flight slot, bit 0 for reader 0
  logic [1:0]                                owner_q [RD_LATENCY];

  // Request vector indexed by client value
  assign req = {rd_req_1, rd_req_0, wr_req};

  // --------------------
  // Round-robin pick
  // --------------------
  always_comb begin
    int idx;
    winner  = last_q;
    any_req = 1'b0;
    // Search starts one past the last winner and wraps
    for (int off = 1; off <= tiled_ram_req_pkg::NUM_CLIENTS; off++) begin
      idx = (int'(last_q) + off) % tiled_ram_req_pkg::NUM_CLIENTS;
      if (!any_req && req[idx]) begin
        winner  = tiled_ram_req_pkg::client_t'(idx);
        any_req = 1'b1;
      end
    end
  end

  // Single grant pulse for the winner
  assign wr_gnt   = any_req && (winner == tiled_ram_req_pkg::WRITER);
  assign rd_gnt_0 = any_req && (winner == tiled_ram_req_pkg::READER_0);
  assign rd_gnt_1 = any_req && (winner == tiled_ram_req_pkg::READER_1);

  // Reset value makes the writer first in line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= tiled_ram_req_pkg::READER_1;
    end else if (any_req) begin
      last_q <= winner;
    end
  end

  // --------------------
  // Command mux
  // --------------------
  assign cmd_valid = any_req;
  assign cmd_kind  = wr_gnt ? tiled_ram_req_pkg::CMD_WRITE : tiled_ram_req_pkg::CMD_READ;
  // Only the writer carries payload
  assign cmd_wdata = wr_data;

  always_comb begin
    case (winner)
      tiled_ram_req_pkg::WRITER:   cmd_addr = wr_addr;
      tiled_ram_req_pkg::READER_0: cmd_addr = rd_addr_0;
      default:                     cmd_addr = rd_addr_1;
    endcase
  end

  // --------------------
  // Response steering
  // --------------------

  // Shift line tracks which reader owns each slot of the read pipeline
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < RD_LATENCY; s++) begin
        owner_q[s] <= 2'b00;
      end
    end else begin
      owner_q[0] <= {rd_gnt_1, rd_gnt_0};
      for (int s = 1; s < RD_LATENCY; s++) begin
        owner_q[s] <= owner_q[s-1];
      end
    end
  end

  // Last slot lines up with rsp_valid
  assign rd_valid_0 = rsp_valid && owner_q[RD_LATENCY-1][0];
  assign rd_valid_1 = rsp_valid && owner_q[RD_LATENCY-1][1];
  assign rd_data_0  = rsp_data;
  assign rd_data_1  = rsp_data;

  // Grants stay exclusive and never appear unrequested
  gnt_onehot0_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({rd_gnt_1, rd_gnt_0, wr_gnt}));
  gnt_has_req_a: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_gnt -> wr_req) && (rd_gnt_0 -> rd_req_0) && (rd_gnt_1 -> rd_req_1));

  // Every response from the data pipe belongs to a granted reader
  rsp_owned_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> (owner_q[RD_LATENCY-1] != 2'b00));

endmodule : ram_port_arbiter

// File: source/tiled_ram_req_pkg.sv
// Tiled RAM request-side types for client identity and command kind

package tiled_ram_req_pkg;

  // Number of peer clients on the arbiter
  localparam int NUM_CLIENTS = 3;

  // Client identifier
  // Values double as the round-robin order
  typedef enum logic [1:0] {
    WRITER   = 2'd0,
    READER_0 = 2'd1,
    READER_1 = 2'd2
  } client_t;

  // Command carried from arbiter to the tiles
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_t;

endpackage : tiled_ram_req_pkg

// File: source/tiled_ram_cfg_pkg.sv
// Tiled RAM storage-shape types shared by the datapath blocks
`include "tiled_ram_defines.svh"

package tiled_ram_cfg_pkg;

  // --------------------
  // Full RAM view
  // --------------------

  // Word address across the whole RAM
  typedef logic [$clog2(`TILED_RAM_DEPTH)-1:0] addr_t;

  // One complete data word
  typedef logic [`TILED_RAM_WIDTH-1:0] data_t;

  // --------------------
  // Per-tile view
  // --------------------

  // Selects one depth tile, taken from the address MSBs
  typedef logic [$clog2(`TILED_RAM_DEPTH_TILES)-1:0] tile_idx_t;

  // Row inside one tile, taken from the address LSBs
  typedef logic [$clog2(`TILED_RAM_DEPTH / `TILED_RAM_DEPTH_TILES)-1:0] tile_addr_t;

  // Slice of a word stored by a single width tile
  typedef logic [(`TILED_RAM_WIDTH / `TILED_RAM_WIDTH_TILES)-1:0] tile_word_t;

endpackage : tiled_ram_cfg_pkg

// File: include/tiled_ram_defines.svh
// Tiled RAM configuration macros for storage shape and pipeline depth
`ifndef TILED_RAM_DEFINES_SVH
`define TILED_RAM_DEFINES_SVH

// --------------------
// Storage shape
// --------------------

// Number of words in the whole RAM
`define TILED_RAM_DEPTH 64

// Word width in bits
`define TILED_RAM_WIDTH 32

// Tiles along depth, power of two and at most the depth
`define TILED_RAM_DEPTH_TILES 4

// Tiles along width, power of two that divides the width
`define TILED_RAM_WIDTH_TILES 2

// --------------------
// Pipeline depth
// --------------------

// Register stages between arbiter and tiles, 0 to 2
`define TILED_RAM_ADDR_STAGES 1

// Register stages in the read merge tree, up to log2 of depth tiles
`define TILED_RAM_DATA_STAGES 1

`endif
